//--- hdl/spi_image_cfg.svh
`ifndef SPI_IMAGE_CFG_SVH
`define SPI_IMAGE_CFG_SVH

// Frame geometry, kept small for simulation.
`define RES_X 8
`define RES_Y 4

`define PIXEL_SIZE 16
`define PRECISION 11

`define FB_DEPTH (`RES_X * `RES_Y)
`define FB_AW 5

`define AXIL_AW 4

`endif

//--- hdl/spi_image_pkg.sv
`include "spi_image_cfg.svh"

package spi_image_pkg;

    typedef struct packed {
        logic [`PIXEL_SIZE-1:0] data;
        logic [`PRECISION-1:0]  x;
        logic [`PRECISION-1:0]  y;
    } pixel_t;

    typedef struct packed {
        logic                   en;
        logic [`FB_AW-1:0]      addr;
        logic [`PIXEL_SIZE-1:0] data;
    } fb_wr_t;

    typedef struct packed {
        logic [`AXIL_AW-1:0] awaddr;
        logic                awvalid;
        logic [31:0]         wdata;
        logic [3:0]          wstrb;
        logic                wvalid;
        logic                bready;
        logic [`AXIL_AW-1:0] araddr;
        logic                arvalid;
        logic                rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

//--- hdl/spi_byte_receiver.sv
`timescale 1ns/1ps

module spi_byte_receiver (
    input  logic       clk,
    input  logic       reset,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    output logic [7:0] byte_out,
    output logic       byte_ready
);
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_n_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic [6:0] shift;
    logic [2:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync <= 2'b00; // Mode 0 idles low.
            mosi_sync <= 2'b00;
            cs_n_sync <= 2'b11;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            cs_n_sync <= {cs_n_sync[0], cs_n};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt    <= 3'd0;
            byte_ready <= 1'b0;
        end else begin
            byte_ready <= 1'b0;
            if (cs_n_sync[1]) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_ready <= 1'b1;
                end
            end
        end
    end

    // MSB arrives first.
    always_ff @(posedge clk) begin
        if (sclk_rise && !cs_n_sync[1]) begin
            shift <= {shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                byte_out <= {shift, mosi_sync[1]};
            end
        end
    end

endmodule

//--- hdl/spi_multibyte_reader.sv
`timescale 1ns/1ps

module spi_multibyte_reader #(
    parameter int BYTE_COUNT = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      spi_byte_ready,
    input  logic [7:0]                spi_byte_in,
    output logic [8*BYTE_COUNT-1:0]   bytes_out,
    output logic                      bytes_ready
);
    localparam int CW = (BYTE_COUNT > 1) ? $clog2(BYTE_COUNT) : 1;

    logic [CW-1:0] byte_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt    <= '0;
            bytes_ready <= 1'b0;
        end else begin
            bytes_ready <= 1'b0;
            if (spi_byte_ready) begin
                if (byte_cnt == CW'(BYTE_COUNT - 1)) begin
                    byte_cnt    <= '0;
                    bytes_ready <= 1'b1; // Group complete.
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (spi_byte_ready) begin
            bytes_out <= (bytes_out << 8) | (8*BYTE_COUNT)'(spi_byte_in);
        end
    end

endmodule

//--- hdl/pipeline_spi_image_receiver.sv
`timescale 1ns/1ps
`include "spi_image_cfg.svh"

module pipeline_spi_image_receiver (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_receive,
    input  logic                  spi_byte_ready,
    input  logic [7:0]            spi_byte_in,
    output spi_image_pkg::pixel_t pixel,
    output logic                  pixel_ready
);
    typedef enum logic {
        AWAIT_ROW,
        AWAIT_PIXEL
    } state_t;

    state_t      state;
    logic [15:0] word;
    logic        word_ready;

    // Disabling drops any half-received word.
    spi_multibyte_reader #(
        .BYTE_COUNT(2)
    ) spi_reader_i (
        .clk            (clk),
        .reset          (reset | ~enable_receive),
        .spi_byte_ready (spi_byte_ready),
        .spi_byte_in    (spi_byte_in),
        .bytes_out      (word),
        .bytes_ready    (word_ready)
    );

    always_ff @(posedge clk) begin
        if (reset || !enable_receive) begin
            state       <= AWAIT_ROW;
            pixel_ready <= 1'b0;
        end else begin
            case (state)
                AWAIT_ROW: begin
                    if (word_ready) begin
                        state <= AWAIT_PIXEL;
                    end
                end
                default: begin
                    pixel_ready <= word_ready; // One-cycle strobe per word.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == AWAIT_ROW) begin
            if (word_ready) begin
                pixel.y <= word[`PRECISION-1:0]; // First word is the row.
                pixel.x <= '0;
            end
        end else begin
            if (word_ready) begin
                pixel.data <= word[`PIXEL_SIZE-1:0];
            end
            if (pixel_ready) begin
                if (pixel.x == `PRECISION'(`RES_X - 1)) begin
                    pixel.x <= '0;
                    if (pixel.y == `PRECISION'(`RES_Y - 1)) begin
                        pixel.y <= '0; // Wrap to top of frame.
                    end else begin
                        pixel.y <= pixel.y + 1'b1;
                    end
                end else begin
                    pixel.x <= pixel.x + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/frame_buffer.sv
`timescale 1ns/1ps
`include "spi_image_cfg.svh"

module frame_buffer (
    input  logic                   clk,
    input  spi_image_pkg::fb_wr_t  wr,
    input  logic [`FB_AW-1:0]      rd_addr,
    output logic [`PIXEL_SIZE-1:0] rd_data
);
    logic [`PIXEL_SIZE-1:0] mem [`FB_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read before write on a shared address.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/axil_image_regs.sv
`timescale 1ns/1ps
`include "spi_image_cfg.svh"

module axil_image_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  spi_image_pkg::axil_req_t axil_req,
    output spi_image_pkg::axil_rsp_t axil_rsp,
    input  spi_image_pkg::pixel_t    pixel,
    input  logic                     pixel_ready,
    output logic                     enable,
    output logic [`FB_AW-1:0]        fb_rd_addr,
    input  logic [`PIXEL_SIZE-1:0]   fb_rd_data
);
    localparam logic [1:0] REG_CTRL     = 2'd0;
    localparam logic [1:0] REG_STATUS   = 2'd1;
    localparam logic [1:0] REG_PIX_ADDR = 2'd2;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_VALID
    } rd_state_t;

    rd_state_t         rd_state;
    logic [1:0]        rd_sel;
    logic [31:0]       rd_mux;
    logic [31:0]       rdata;
    logic              bvalid;
    logic              wr_hs;
    logic              ar_hs;
    logic              ctrl_rise;
    logic [31:0]       wr_old;
    logic [31:0]       wr_merged;
    logic [`FB_AW-1:0] pix_addr;
    logic [15:0]       pix_cnt;
    logic [15:0]       frame_cnt;

    assign wr_hs = axil_req.awvalid & axil_req.wvalid & ~bvalid;
    assign ar_hs = axil_req.arvalid & (rd_state == RD_IDLE);

    // Byte strobes merge into the current register value.
    always_comb begin
        wr_old = (axil_req.awaddr[3:2] == REG_CTRL) ? {31'b0, enable} : 32'(pix_addr);
        for (int i = 0; i < 4; i++) begin
            wr_merged[8*i +: 8] = axil_req.wstrb[i] ? axil_req.wdata[8*i +: 8]
                                                     : wr_old[8*i +: 8];
        end
    end

    assign ctrl_rise = wr_hs & (axil_req.awaddr[3:2] == REG_CTRL) & wr_merged[0] & ~enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            enable   <= 1'b0;
            pix_addr <= '0;
            bvalid   <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
                case (axil_req.awaddr[3:2])
                    REG_CTRL:     enable   <= wr_merged[0];
                    REG_PIX_ADDR: pix_addr <= wr_merged[`FB_AW-1:0];
                    default:      ; // STATUS and PIX_DATA ignore writes.
                endcase
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl_rise) begin
            pix_cnt   <= '0;
            frame_cnt <= '0;
        end else if (pixel_ready) begin
            pix_cnt <= pix_cnt + 16'd1;
            if (pixel.x == `PRECISION'(`RES_X - 1) && pixel.y == `PRECISION'(`RES_Y - 1)) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
        end
    end

    assign fb_rd_addr = pix_addr;

    always_comb begin
        case (rd_sel)
            REG_CTRL:     rd_mux = {31'b0, enable};
            REG_STATUS:   rd_mux = {frame_cnt, pix_cnt};
            REG_PIX_ADDR: rd_mux = 32'(pix_addr);
            default:      rd_mux = 32'(fb_rd_data);
        endcase
    end

    // The extra wait state covers the frame buffer read.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_hs) begin
                        rd_state <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    rd_state <= RD_VALID;
                end
                default: begin
                    if (axil_req.rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_sel <= axil_req.araddr[3:2];
        end
        if (rd_state == RD_WAIT) begin
            rdata <= rd_mux;
        end
    end

    always_comb begin
        axil_rsp         = '0; // Responses are always OKAY.
        axil_rsp.awready = wr_hs;
        axil_rsp.wready  = wr_hs;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = (rd_state == RD_IDLE);
        axil_rsp.rdata   = rdata;
        axil_rsp.rvalid  = (rd_state == RD_VALID);
    end

endmodule

//--- hdl/spi_image_top.sv
`timescale 1ns/1ps
`include "spi_image_cfg.svh"

module spi_image_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sclk,
    input  logic                     mosi,
    input  logic                     cs_n,
    input  spi_image_pkg::axil_req_t axil_req,
    output spi_image_pkg::axil_rsp_t axil_rsp
);
    logic [7:0]             spi_byte;
    logic                   spi_byte_ready;
    spi_image_pkg::pixel_t  pixel;
    logic                   pixel_ready;
    logic                   enable;
    spi_image_pkg::fb_wr_t  fb_wr;
    logic [`FB_AW-1:0]      fb_rd_addr;
    logic [`PIXEL_SIZE-1:0] fb_rd_data;

    spi_byte_receiver spi_byte_receiver_i (
        .clk        (clk),
        .reset      (reset),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n),
        .byte_out   (spi_byte),
        .byte_ready (spi_byte_ready)
    );

    pipeline_spi_image_receiver receiver_i (
        .clk            (clk),
        .reset          (reset),
        .enable_receive (enable),
        .spi_byte_ready (spi_byte_ready),
        .spi_byte_in    (spi_byte),
        .pixel          (pixel),
        .pixel_ready    (pixel_ready)
    );

    // Row-major frame buffer address.
    assign fb_wr.en   = pixel_ready;
    assign fb_wr.addr = `FB_AW'(pixel.y * `RES_X + pixel.x);
    assign fb_wr.data = pixel.data;

    frame_buffer frame_buffer_i (
        .clk     (clk),
        .wr      (fb_wr),
        .rd_addr (fb_rd_addr),
        .rd_data (fb_rd_data)
    );

    axil_image_regs axil_image_regs_i (
        .clk         (clk),
        .reset       (reset),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .pixel       (pixel),
        .pixel_ready (pixel_ready),
        .enable      (enable),
        .fb_rd_addr  (fb_rd_addr),
        .fb_rd_data  (fb_rd_data)
    );

endmodule

//--- verif/spi_image_checker.sv
`timescale 1ns/1ps
`include "spi_image_cfg.svh"

module spi_image_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  spi_image_pkg::axil_req_t axil_req,
    input  spi_image_pkg::axil_rsp_t axil_rsp,
    input  logic [31:0]              exp_rdata,
    output int                       data_errs,
    output int                       proto_errs
);
    logic [`AXIL_AW+31:0] pending [$]; // Address and expected data per accepted read.
    logic [`AXIL_AW+31:0] entry;
    logic                 r_wait;
    logic                 b_wait;
    logic [31:0]          r_last;

    function automatic string reg_name(input logic [`AXIL_AW-1:0] addr);
        case (addr[3:2])
            2'd0:    return "CTRL";
            2'd1:    return "STATUS";
            2'd2:    return "PIX_ADDR";
            default: return "PIX_DATA";
        endcase
    endfunction

    initial begin
        data_errs  = 0;
        proto_errs = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            r_wait <= 1'b0;
            b_wait <= 1'b0;
        end else begin
            if (axil_req.arvalid && axil_rsp.arready) begin
                pending.push_back({axil_req.araddr, exp_rdata});
            end
            if (axil_rsp.awready !== axil_rsp.wready
                    || (axil_rsp.awready && !(axil_req.awvalid && axil_req.wvalid))) begin
                $display("At %0t awready and wready did not rise together with both valids",
                         $time);
                proto_errs++;
            end
            if (r_wait && (!axil_rsp.rvalid || axil_rsp.rdata !== r_last)) begin
                $display("At %0t the read response changed before rready was seen", $time);
                proto_errs++;
            end
            if (b_wait && !axil_rsp.bvalid) begin
                $display("At %0t bvalid dropped before bready was seen", $time);
                proto_errs++;
            end
            r_wait <= axil_rsp.rvalid && !axil_req.rready; // Response still owed.
            b_wait <= axil_rsp.bvalid && !axil_req.bready;
            r_last <= axil_rsp.rdata;
            if (axil_rsp.rvalid && axil_req.rready) begin
                if (pending.size() == 0) begin
                    $display("At %0t a read response came with no read outstanding", $time);
                    proto_errs++;
                end else begin
                    entry = pending.pop_front();
                    if (axil_rsp.rdata !== entry[31:0]) begin
                        $display("ERR %0t axil_rsp.rdata (%s) expected %h actual %h", $time,
                                 reg_name(entry[`AXIL_AW+31:32]), entry[31:0], axil_rsp.rdata);
                        data_errs++;
                    end
                end
                if (axil_rsp.rresp !== 2'b00) begin
                    $display("ERR %0t axil_rsp.rresp expected 0 actual %h", $time,
                             axil_rsp.rresp);
                    data_errs++;
                end
            end
            if (axil_rsp.bvalid && axil_req.bready && axil_rsp.bresp !== 2'b00) begin
                $display("ERR %0t axil_rsp.bresp expected 0 actual %h", $time, axil_rsp.bresp);
                data_errs++;
            end
        end
    end

endmodule

//--- verif/spi_image_tb.sv
`timescale 1ns/1ps
`include "spi_image_cfg.svh"

module spi_image_tb;
    localparam int SPI_BITS = 16 * (1 + 40 + 1 + 6) + 8 * 3; // Two runs plus loose bytes.
    localparam int TIMEOUT  = 2 * SPI_BITS * 8 + 2000;

    logic                     clk;
    logic                     reset;
    logic                     sclk;
    logic                     mosi;
    logic                     cs_n;
    spi_image_pkg::axil_req_t axil_req;
    spi_image_pkg::axil_rsp_t axil_rsp;
    logic [31:0]              exp_rdata;
    int                       data_errs;
    int                       proto_errs;
    int                       cycle_cnt;
    logic [`PIXEL_SIZE-1:0]   shadow [`FB_DEPTH]; // Model of the frame buffer.
    int                       mx;
    int                       my;
    int                       pix_cnt;
    int                       frame_cnt;
    int                       row;

    spi_image_top spi_image_top_i (
        .clk      (clk),
        .reset    (reset),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    spi_image_checker spi_image_checker_i (
        .clk        (clk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .exp_rdata  (exp_rdata),
        .data_errs  (data_errs),
        .proto_errs (proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Mode 0, MSB first, chip select framed per byte.
    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        cs_n <= 1'b0;
        for (int i = 7; i >= 0; i--) begin
            mosi <= b[i];
            repeat (4) @(posedge clk);
            sclk <= 1'b1;
            repeat (4) @(posedge clk);
            sclk <= 1'b0;
        end
        repeat (4) @(posedge clk);
        cs_n <= 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_word(input logic [15:0] w);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        axil_req.wvalid  <= 1'b1;
        do @(posedge clk); while (!axil_rsp.awready);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        repeat ($urandom % 4) @(posedge clk);
        axil_req.bready <= 1'b1;
        do @(posedge clk); while (!axil_rsp.bvalid);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input logic [31:0] exp);
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        exp_rdata        <= exp; // Taken by the checker at the address handshake.
        do @(posedge clk); while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        repeat ($urandom % 4) @(posedge clk);
        axil_req.rready <= 1'b1;
        do @(posedge clk); while (!axil_rsp.rvalid);
        axil_req.rready <= 1'b0;
    endtask

    task automatic set_enable(input logic on);
        axi_write(4'h0, 32'(on));
        if (on) begin
            pix_cnt   = 0; // Counters clear on the rising edge.
            frame_cnt = 0;
        end
    endtask

    task automatic model_pixel(input logic [15:0] d);
        shadow[my * `RES_X + mx] = d;
        pix_cnt++;
        if (mx == `RES_X - 1 && my == `RES_Y - 1) begin
            frame_cnt++;
        end
        if (mx == `RES_X - 1) begin
            mx = 0;
            my = (my == `RES_Y - 1) ? 0 : my + 1;
        end else begin
            mx++;
        end
    endtask

    task automatic receive_run(input int n);
        logic [15:0] pix;
        row = $urandom % `RES_Y;
        send_word(16'(row)); // Row word first.
        mx = 0;
        my = row;
        repeat (n) begin
            pix = 16'($urandom);
            send_word(pix);
            model_pixel(pix);
        end
    endtask

    task automatic check_frame();
        for (int a = 0; a < `FB_DEPTH; a++) begin
            axi_write(4'h8, 32'(a));
            axi_read(4'hC, 32'(shadow[a]));
        end
    endtask

    initial begin
        reset     = 1'b1;
        sclk      = 1'b0;
        mosi      = 1'b0;
        cs_n      = 1'b1;
        axil_req  = '0;
        exp_rdata = '0;
        pix_cnt   = 0;
        frame_cnt = 0;
        row       = $urandom(32'h131);
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        axi_read(4'h0, 32'h0);
        axi_read(4'h4, 32'h0);
        set_enable(1'b1);
        axi_read(4'h0, 32'h1);
        axi_write(4'h8, 32'h13);
        axi_read(4'h8, 32'h13);

        receive_run(40); // Wraps past the end of the frame.
        check_frame();
        axi_read(4'h4, {frame_cnt[15:0], pix_cnt[15:0]});
        set_enable(1'b0);
        set_enable(1'b1);
        axi_read(4'h4, 32'h0);

        send_byte(8'($urandom)); // Half a row word.
        set_enable(1'b0);
        send_byte(8'($urandom));
        send_byte(8'($urandom));
        check_frame();
        set_enable(1'b1);
        receive_run(6);
        check_frame();
        axi_read(4'h4, {frame_cnt[15:0], pix_cnt[15:0]});

        repeat (10) @(posedge clk);
        $display("Data errors: %0d, protocol errors: %0d", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("The run did not finish within %0d cycles", TIMEOUT);
        $display("Data errors: %0d, protocol errors: %0d", data_errs, proto_errs);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/spi_image_pkg.sv
hdl/spi_byte_receiver.sv
hdl/spi_multibyte_reader.sv
hdl/pipeline_spi_image_receiver.sv
hdl/frame_buffer.sv
hdl/axil_image_regs.sv
hdl/spi_image_top.sv
verif/spi_image_checker.sv
verif/spi_image_tb.sv

//--- Bender.yml
package:
  name: spi_image

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/spi_image_pkg.sv
      - hdl/spi_byte_receiver.sv
      - hdl/spi_multibyte_reader.sv
      - hdl/pipeline_spi_image_receiver.sv
      - hdl/frame_buffer.sv
      - hdl/axil_image_regs.sv
      - hdl/spi_image_top.sv
  - target: simulation
    files:
      - verif/spi_image_checker.sv
      - verif/spi_image_tb.sv
